/* design/mem_pkg.sv */
package mem_pkg;

    // Address widths are fixed by the union layout
    localparam int ADDR_W  = 12;
    localparam int INDEX_W = 4;
    localparam int OFFS_W  = 2;
    localparam int TAG_W   = ADDR_W - INDEX_W - OFFS_W;

    // Access size, bit 2 marks an unsigned load
    typedef enum logic [2:0] {
        SZ_B  = 3'b000,
        SZ_H  = 3'b001,
        SZ_W  = 3'b010,
        SZ_BU = 3'b100,
        SZ_HU = 3'b101
    } size_e;

    // Cache view of a byte address
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [OFFS_W-1:0]  offset;
    } cache_addr_t;

    // Same address bits, seen flat by the backing store
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        cache_addr_t       cache;
    } mem_addr_u;

endpackage

/* design/store_bus_if.sv */
`timescale 1ns/1ps

interface store_bus_if;

    logic              start;    // One-cycle pulse
    logic              we;
    mem_pkg::mem_addr_u addr;
    logic [3:0]        byte_en;
    logic [31:0]       wdata;    // Already lane-positioned
    logic              done;     // MEM_LATENCY cycles after start
    logic [31:0]       rdata;    // Aligned word, valid with done

    modport sequencer (
        output start,
        output we,
        output addr,
        output byte_en,
        output wdata,
        input  done,
        input  rdata
    );

    modport store (
        input  start,
        input  we,
        input  addr,
        input  byte_en,
        input  wdata,
        output done,
        output rdata
    );

endinterface

/* design/cache_bus_if.sv */
`timescale 1ns/1ps

interface cache_bus_if;

    logic               lookup;
    mem_pkg::mem_addr_u addr;
    logic               update;       // Store hit, merge under byte_en
    logic [3:0]         byte_en;
    logic [31:0]        wdata;
    logic               refill;       // Whole line plus tag and valid
    logic [31:0]        refill_data;
    logic               hit;          // Cycle after lookup
    logic [31:0]        rdata;

    modport sequencer (
        output lookup,
        output addr,
        output update,
        output byte_en,
        output wdata,
        output refill,
        output refill_data,
        input  hit,
        input  rdata
    );

    modport cache (
        input  lookup,
        input  addr,
        input  update,
        input  byte_en,
        input  wdata,
        input  refill,
        input  refill_data,
        output hit,
        output rdata
    );

endinterface

/* design/access_sequencer.sv */
`timescale 1ns/1ps

module access_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic                  we,
    input  mem_pkg::size_e        size,
    input  mem_pkg::mem_addr_u    addr,
    input  logic [31:0]           wdata,
    output logic                  busy,
    output logic                  ret_cache,
    output logic                  ret_mem,
    output logic                  ret_is_load,
    output mem_pkg::size_e        ret_size,
    output mem_pkg::mem_addr_u    ret_addr,
    cache_bus_if.sequencer        cbus,
    store_bus_if.sequencer        sbus
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_LOOKUP   = 3'd1;
    localparam logic [2:0] S_DECIDE   = 3'd2;
    localparam logic [2:0] S_MEM_WAIT = 3'd3;
    localparam logic [2:0] S_RETURN   = 3'd4;   // Ready cycle, takes a new req

    logic [2:0]         state;
    logic [2:0]         state_nxt;
    logic               accept;
    logic               h_we;
    mem_pkg::size_e     h_size;
    mem_pkg::mem_addr_u h_addr;
    logic [31:0]        h_wdata;
    logic [3:0]         lane_en;
    logic [31:0]        lane_wdata;

    assign accept = req && (state == S_IDLE || state == S_RETURN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE, S_RETURN: state_nxt = req ? S_LOOKUP : S_IDLE;
            S_LOOKUP:         state_nxt = S_DECIDE;
            S_DECIDE:         state_nxt = (!h_we && cbus.hit) ? S_RETURN : S_MEM_WAIT;
            S_MEM_WAIT:       state_nxt = sbus.done ? S_RETURN : S_MEM_WAIT;
            default:          state_nxt = S_IDLE;
        endcase
    end

    // Request held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            h_we    <= we;
            h_size  <= size;
            h_addr  <= addr;
            h_wdata <= wdata;
        end
    end

    // Lane enables and replicated store data
    always_comb begin
        case (h_size)
            mem_pkg::SZ_B, mem_pkg::SZ_BU: begin
                lane_en    = 4'b0001 << h_addr.cache.offset;
                lane_wdata = {4{h_wdata[7:0]}};
            end
            mem_pkg::SZ_H, mem_pkg::SZ_HU: begin
                lane_en    = 4'b0011 << h_addr.cache.offset;
                lane_wdata = {2{h_wdata[15:0]}};
            end
            default: begin
                lane_en    = 4'b1111;
                lane_wdata = h_wdata;
            end
        endcase
    end

    assign busy = (state != S_IDLE) && (state != S_RETURN);

    assign cbus.lookup      = (state == S_LOOKUP);
    assign cbus.addr        = h_addr;
    assign cbus.byte_en     = lane_en;
    assign cbus.wdata       = lane_wdata;
    assign cbus.update      = (state == S_DECIDE) && h_we && cbus.hit;
    assign cbus.refill      = (state == S_MEM_WAIT) && sbus.done && !h_we;
    assign cbus.refill_data = sbus.rdata;

    // Write-through on every store, fetch on a load miss
    assign sbus.start   = (state == S_DECIDE) && (h_we || !cbus.hit);
    assign sbus.we      = h_we;
    assign sbus.addr    = h_addr;
    assign sbus.byte_en = lane_en;
    assign sbus.wdata   = lane_wdata;

    assign ret_cache   = (state == S_DECIDE) && !h_we && cbus.hit;
    assign ret_mem     = (state == S_MEM_WAIT) && sbus.done;
    assign ret_is_load = !h_we;
    assign ret_size    = h_size;
    assign ret_addr    = h_addr;

endmodule

/* design/data_cache.sv */
`timescale 1ns/1ps

module data_cache (
    input  logic      clk,
    input  logic      rst_n,
    cache_bus_if.cache bus
);

    localparam int LINES = 2 ** mem_pkg::INDEX_W;

    logic [LINES-1:0]          valid_q;
    logic [mem_pkg::TAG_W-1:0] tag_q [LINES];
    logic [31:0]               data_q [LINES];
    logic                      hit_q;
    logic [31:0]               rdata_q;
    logic [31:0]               merged;
    logic                      match;

    assign match = valid_q[bus.addr.cache.index]
                && (tag_q[bus.addr.cache.index] == bus.addr.cache.tag);

    // Byte merge of store data into the resident word
    always_comb begin
        merged = data_q[bus.addr.cache.index];
        for (int i = 0; i < 4; i++) begin
            if (bus.byte_en[i]) begin
                merged[8*i +: 8] = bus.wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            hit_q   <= 1'b0;
        end else begin
            hit_q <= bus.lookup && match;
            if (bus.refill) begin
                valid_q[bus.addr.cache.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.refill) begin
            data_q[bus.addr.cache.index] <= bus.refill_data;
            tag_q[bus.addr.cache.index]  <= bus.addr.cache.tag;
        end else if (bus.update) begin
            data_q[bus.addr.cache.index] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.lookup) begin
            rdata_q <= data_q[bus.addr.cache.index];
        end
    end

    assign bus.hit   = hit_q;
    assign bus.rdata = rdata_q;

endmodule

/* design/backing_store.sv */
`timescale 1ns/1ps

module backing_store #(
    parameter int MEM_LATENCY = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    store_bus_if.store bus
);

    localparam int MEM_BYTES = 2 ** mem_pkg::ADDR_W;
    localparam int CNT_W     = $clog2(MEM_LATENCY + 1);
    localparam logic [CNT_W-1:0] LAT_M1 = CNT_W'(MEM_LATENCY - 1);

    logic [7:0]                       mem_q [MEM_BYTES];
    logic [CNT_W-1:0]                 cnt_q;
    logic                             done_q;
    logic                             fire;
    logic [31:0]                      rdata_q;
    logic [mem_pkg::ADDR_W-3:0]       word_addr;

    assign word_addr = bus.addr.flat[mem_pkg::ADDR_W-1:2];

    // Access completes on the edge that raises done
    assign fire = bus.start ? (MEM_LATENCY == 1) : (cnt_q == CNT_W'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
            for (int j = 0; j < MEM_BYTES; j++) begin
                mem_q[j] <= 8'h00;
            end
        end else begin
            done_q <= fire;
            if (bus.start) begin
                cnt_q <= LAT_M1;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
            if (fire && bus.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (bus.byte_en[i]) begin
                        mem_q[{word_addr, 2'(i)}] <= bus.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !bus.we) begin
            rdata_q <= {mem_q[{word_addr, 2'd3}], mem_q[{word_addr, 2'd2}],
                        mem_q[{word_addr, 2'd1}], mem_q[{word_addr, 2'd0}]};
        end
    end

    assign bus.done  = done_q;
    assign bus.rdata = rdata_q;

endmodule

/* design/load_return.sv */
`timescale 1ns/1ps

module load_return (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ret_cache,
    input  logic               ret_mem,
    input  mem_pkg::size_e     ret_size,
    input  mem_pkg::mem_addr_u ret_addr,
    input  logic [31:0]        cache_word,
    input  logic [31:0]        mem_word,
    input  logic               ret_is_load,
    output logic [31:0]        rdata,
    output logic               ready
);

    logic [31:0] word;
    logic [31:0] shifted;
    logic [31:0] result;

    assign word    = ret_cache ? cache_word : mem_word;
    assign shifted = word >> {ret_addr.cache.offset, 3'b000};   // Lane to bit 0

    always_comb begin
        case (ret_size)
            mem_pkg::SZ_B:  result = {{24{shifted[7]}}, shifted[7:0]};
            mem_pkg::SZ_BU: result = {24'h0, shifted[7:0]};
            mem_pkg::SZ_H:  result = {{16{shifted[15]}}, shifted[15:0]};
            mem_pkg::SZ_HU: result = {16'h0, shifted[15:0]};
            mem_pkg::SZ_W:  result = word;
            default:        result = 32'h0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b0;
            rdata <= 32'h0;
        end else begin
            ready <= ret_cache || ret_mem;
            if (ret_cache || ret_mem) begin
                rdata <= ret_is_load ? result : 32'h0;   // Stores return zero
            end
        end
    end

endmodule

/* design/mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req,
    input  logic                       we,
    input  logic [2:0]                 size,
    input  logic [mem_pkg::ADDR_W-1:0] addr,
    input  logic [31:0]                wdata,
    output logic [31:0]                rdata,
    output logic                       ready,
    output logic                       busy
);

    logic               ret_cache;
    logic               ret_mem;
    logic               ret_is_load;
    mem_pkg::size_e     ret_size;
    mem_pkg::mem_addr_u ret_addr;

    cache_bus_if cbus ();
    store_bus_if sbus ();

    access_sequencer i_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .we          (we),
        .size        (mem_pkg::size_e'(size)),
        .addr        (addr),
        .wdata       (wdata),
        .busy        (busy),
        .ret_cache   (ret_cache),
        .ret_mem     (ret_mem),
        .ret_is_load (ret_is_load),
        .ret_size    (ret_size),
        .ret_addr    (ret_addr),
        .cbus        (cbus.sequencer),
        .sbus        (sbus.sequencer)
    );

    data_cache i_cache (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (cbus.cache)
    );

    backing_store #(
        .MEM_LATENCY (MEM_LATENCY)
    ) i_store (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (sbus.store)
    );

    load_return i_return (
        .clk         (clk),
        .rst_n       (rst_n),
        .ret_cache   (ret_cache),
        .ret_mem     (ret_mem),
        .ret_size    (ret_size),
        .ret_addr    (ret_addr),
        .cache_word  (cbus.rdata),
        .mem_word    (sbus.rdata),
        .ret_is_load (ret_is_load),
        .rdata       (rdata),
        .ready       (ready)
    );

endmodule

/* sim/mem_subsystem_assert.sv */
`timescale 1ns/1ps

module mem_subsystem_assert (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       req,
    input logic                       busy,
    input logic                       ready,
    input logic [2:0]                 size,
    input logic [mem_pkg::ADDR_W-1:0] addr
);

    logic size_legal;
    logic aligned;

    assign size_legal = (size == mem_pkg::SZ_B) || (size == mem_pkg::SZ_H)
                     || (size == mem_pkg::SZ_W) || (size == mem_pkg::SZ_BU)
                     || (size == mem_pkg::SZ_HU);
    assign aligned = (size[1:0] == 2'b00)
                  || (size[1:0] == 2'b01 && !addr[0])
                  || (size[1:0] == 2'b10 && addr[1:0] == 2'b00);

    no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n) req |-> !busy)
        else $error("req raised while busy");

    ready_single_pulse: assert property (@(posedge clk) disable iff (!rst_n) ready |=> !ready)
        else $error("ready held for more than one cycle");

    idle_after_ready: assert property (@(posedge clk) disable iff (!rst_n) ready |=> !busy)
        else $error("busy high in the cycle after ready");

    legal_size: assert property (@(posedge clk) disable iff (!rst_n) req |-> size_legal)
        else $error("illegal access size 0x%0h", size);

    aligned_addr: assert property (@(posedge clk) disable iff (!rst_n) req |-> aligned)
        else $error("misaligned address 0x%03h", addr);

endmodule

bind mem_subsystem mem_subsystem_assert i_assert (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .busy  (busy),
    .ready (ready),
    .size  (size),
    .addr  (addr)
);

/* sim/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int MEM_LATENCY = 4;
    localparam int TIMEOUT     = 50;
    localparam int NUM_RANDOM  = 500;
    localparam int AW          = mem_pkg::ADDR_W;
    localparam logic [AW-1:0] ADDR_A = {6'h05, 4'h3, 2'b00};
    localparam logic [AW-1:0] ADDR_B = {6'h2a, 4'h3, 2'b00};   // Same index as ADDR_A

    logic          clk;
    logic          rst_n;
    logic          req;
    logic          we;
    logic [2:0]    size;
    logic [AW-1:0] addr;
    logic [31:0]   wdata;
    logic [31:0]   rdata;
    logic          ready;
    logic          busy;

    logic [7:0]                model_mem [2 ** AW];
    logic                      model_valid [2 ** mem_pkg::INDEX_W];
    logic [mem_pkg::TAG_W-1:0] model_tag [2 ** mem_pkg::INDEX_W];

    mem_subsystem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .we    (we),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ready (ready),
        .busy  (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Little endian with the low lane at the lower address
    function automatic void model_store(input logic [2:0] sz, input logic [AW-1:0] a,
                                        input logic [31:0] d);
        int          nbytes;
        logic [AW-1:0] ba;
        nbytes = (sz[1:0] == 2'b10) ? 4 : (sz[0] ? 2 : 1);
        for (int i = 0; i < nbytes; i++) begin
            ba = a + AW'(i);
            model_mem[ba] = d[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] model_load(input logic [2:0] sz, input logic [AW-1:0] a);
        logic [AW-1:0] base;
        logic [15:0]   half;
        base = {a[AW-1:2], 2'b00};
        half = {model_mem[a + AW'(1)], model_mem[a]};
        case (sz)
            mem_pkg::SZ_B:  return {{24{model_mem[a][7]}}, model_mem[a]};
            mem_pkg::SZ_BU: return {24'h0, model_mem[a]};
            mem_pkg::SZ_H:  return {{16{half[15]}}, half};
            mem_pkg::SZ_HU: return {16'h0, half};
            mem_pkg::SZ_W:  return {model_mem[base + AW'(3)], model_mem[base + AW'(2)],
                                    model_mem[base + AW'(1)], model_mem[base]};
            default:        return 32'h0;
        endcase
    endfunction

    // Tag model where only load misses allocate
    function automatic logic predict_hit(input logic is_load, input logic [AW-1:0] a);
        logic [mem_pkg::INDEX_W-1:0] idx;
        logic [mem_pkg::TAG_W-1:0]   tag;
        logic                        hit;
        idx = a[mem_pkg::OFFS_W +: mem_pkg::INDEX_W];
        tag = a[AW-1 -: mem_pkg::TAG_W];
        hit = model_valid[idx] && (model_tag[idx] == tag);
        if (is_load && !hit) begin
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
        end
        return hit;
    endfunction

    function automatic logic [2:0] rand_size(input logic is_store);
        case ($urandom_range(0, is_store ? 2 : 4))
            0:       return mem_pkg::SZ_B;
            1:       return mem_pkg::SZ_H;
            2:       return mem_pkg::SZ_W;
            3:       return mem_pkg::SZ_BU;
            default: return mem_pkg::SZ_HU;
        endcase
    endfunction

    // Two tags on two indexes, so conflicts are frequent
    function automatic logic [AW-1:0] rand_addr(input logic [2:0] sz);
        logic [mem_pkg::TAG_W-1:0]   tag;
        logic [mem_pkg::INDEX_W-1:0] idx;
        logic [1:0]                  off;
        tag = ($urandom_range(0, 1) == 0) ? 6'h05 : 6'h2a;
        idx = ($urandom_range(0, 1) == 0) ? 4'h3 : 4'hc;
        off = 2'($urandom_range(0, 3));
        if (sz[1]) off = 2'b00;
        else if (sz[0]) off[0] = 1'b0;
        return {tag, idx, off};
    endfunction

    task automatic do_access(input logic is_store, input logic [2:0] sz,
                             input logic [AW-1:0] a, input logic [31:0] d);
        int          cycles;
        int          exp_lat;
        logic [31:0] exp_data;
        logic        hit;
        hit      = predict_hit(!is_store, a);
        exp_lat  = (hit && !is_store) ? 3 : 3 + MEM_LATENCY;
        exp_data = 32'h0;
        if (is_store) model_store(sz, a, d);
        else exp_data = model_load(sz, a);
        @(negedge clk);
        req   = 1'b1;
        we    = is_store;
        size  = sz;
        addr  = a;
        wdata = d;
        @(negedge clk);
        req    = 1'b0;
        cycles = 1;
        while (!ready) begin
            check_value("busy", 32'(busy), 32'h1);
            if (cycles >= TIMEOUT) begin
                $display("Timeout: no ready within %0d cycles for address 0x%03h", TIMEOUT, a);
                $display("sim failed");
                $fatal(1);
            end
            @(negedge clk);
            cycles++;
        end
        check_value("ready latency", 32'(cycles), 32'(exp_lat));
        check_value("rdata", rdata, exp_data);
        check_value("busy", 32'(busy), 32'h0);
    endtask

    initial begin
        logic       is_store;
        logic [2:0] sz;
        void'($urandom(32'h0890_ab2e));
        rst_n = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        size  = mem_pkg::SZ_W;
        addr  = '0;
        wdata = 32'h0;
        for (int i = 0; i < 2 ** AW; i++) model_mem[i] = 8'h00;
        for (int i = 0; i < 2 ** mem_pkg::INDEX_W; i++) model_valid[i] = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_value("busy", 32'(busy), 32'h0);
            check_value("ready", 32'(ready), 32'h0);
        end

        do_access(1'b1, mem_pkg::SZ_W, ADDR_A, 32'h80f1_7f8e);   // Store miss with write-through
        do_access(1'b0, mem_pkg::SZ_W, ADDR_A, 32'h0);           // Load miss and refill
        repeat (3) do_access(1'b0, mem_pkg::SZ_W, ADDR_A, 32'h0);
        for (int off = 0; off < 4; off++) begin
            do_access(1'b0, mem_pkg::SZ_B, ADDR_A | AW'(off), 32'h0);
            do_access(1'b0, mem_pkg::SZ_BU, ADDR_A | AW'(off), 32'h0);
            if (off % 2 == 0) begin
                do_access(1'b0, mem_pkg::SZ_H, ADDR_A | AW'(off), 32'h0);
                do_access(1'b0, mem_pkg::SZ_HU, ADDR_A | AW'(off), 32'h0);
            end
        end
        do_access(1'b1, mem_pkg::SZ_B, ADDR_A | AW'(1), 32'h1234_565a);
        do_access(1'b1, mem_pkg::SZ_H, ADDR_A | AW'(2), 32'h9876_c3d4);
        do_access(1'b0, mem_pkg::SZ_W, ADDR_A, 32'h0);   // Merged word from the cache
        do_access(1'b0, mem_pkg::SZ_W, ADDR_B, 32'h0);   // Evicts ADDR_A
        do_access(1'b0, mem_pkg::SZ_W, ADDR_A, 32'h0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            is_store = 1'($urandom_range(0, 1));
            sz       = rand_size(is_store);
            do_access(is_store, sz, rand_addr(sz), $urandom);
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* flist.f */
design/mem_pkg.sv
design/store_bus_if.sv
design/cache_bus_if.sv
design/access_sequencer.sv
design/data_cache.sv
design/backing_store.sv
design/load_return.sv
design/mem_subsystem.sv
sim/mem_subsystem_assert.sv
sim/tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_subsystem -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mem_subsystem > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
